//--- design/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// word address width of the backing memory
`define CACHE_AW 12

// number of sets, power of two
`define CACHE_SETS 16

// byte lanes per word
`define CACHE_SEL_W 4

`endif

//--- design/cache_pkg.sv
`default_nettype none

`include "cache_macros.svh"

package cache_pkg;

    localparam int SET_W = $clog2(`CACHE_SETS);
    localparam int TAG_W = `CACHE_AW - SET_W;

    typedef logic [31:0]            word_t;
    typedef logic [`CACHE_AW+1:0]   byte_addr_t;
    typedef logic [`CACHE_AW-1:0]   wb_adr_t;
    typedef logic [SET_W-1:0]       set_t;
    typedef logic [TAG_W-1:0]       tag_t;
    typedef logic [`CACHE_SEL_W-1:0] sel_t;
    typedef logic [1:0]             mem_size_t;

    localparam mem_size_t SZ_BYTE = 2'd0;
    localparam mem_size_t SZ_HALF = 2'd1;
    localparam mem_size_t SZ_WORD = 2'd2;

    typedef struct packed {
        byte_addr_t addr;
        word_t      data;
        mem_size_t  size;
        logic       write;
        logic       valid;
    } cpu_req_t;

    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        word_t   dat;
        sel_t    sel;
    } wb_req_t;

    typedef struct packed {
        logic  stall;
        logic  ack;
        word_t dat;
        logic  err;
    } wb_rsp_t;

    typedef struct packed {
        logic  hit;
        word_t data;
    } lookup_t;

    typedef struct packed {
        logic  done;
        logic  err;
        logic  we;
        word_t rdata;
    } bus_done_t;

    typedef enum logic [1:0] {
        B_IDLE,
        B_REQ,
        B_WAIT
    } bus_state_t;

endpackage

`default_nettype wire

//--- design/store_format.sv
`default_nettype none

module store_format
    import cache_pkg::*;
(
    input  wire word_t     data_i,
    input  wire logic [1:0] offset_i,
    input  wire mem_size_t size_i,
    output word_t          data_o,
    output sel_t           sel_o
);

    always_comb begin
        data_o = data_i;
        sel_o  = '1;
        case (size_i)
            SZ_BYTE: begin
                // byte copied to every lane, select picks the one addressed
                data_o = {4{data_i[7:0]}};
                sel_o  = sel_t'(1) << offset_i;
            end
            SZ_HALF: begin
                // only offset bit 1 matters for halfwords
                data_o = {2{data_i[15:0]}};
                if (offset_i[1]) begin
                    sel_o = 4'b1100;
                end else begin
                    sel_o = 4'b0011;
                end
            end
            SZ_WORD: begin
                data_o = data_i;
                sel_o  = '1;
            end
            default: begin
                // unused size code, treated as a full word
                data_o = data_i;
                sel_o  = '1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/cache_store.sv
`default_nettype none

`include "cache_macros.svh"

module cache_store
    import cache_pkg::*;
(
    input  wire logic       cpu_clock_i,
    input  wire logic       rst_n_i,
    input  wire byte_addr_t addr_i,
    input  wire logic       install_i,
    input  wire word_t      fill_data_i,
    input  wire logic       update_i,
    input  wire word_t      update_data_i,
    input  wire sel_t       update_sel_i,
    output lookup_t         lookup_o
);

    set_t set_idx;
    tag_t addr_tag;

    tag_t  tag_mem  [`CACHE_SETS];
    word_t data_mem [`CACHE_SETS];
    logic [`CACHE_SETS-1:0] valid_q;

    // word address split, byte offset is not part of the index
    assign set_idx  = addr_i[SET_W+1:2];
    assign addr_tag = addr_i[$bits(byte_addr_t)-1:SET_W+2];

    always_ff @(posedge cpu_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (install_i) begin
            valid_q[set_idx] <= 1'b1;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (install_i) begin
            tag_mem[set_idx]  <= addr_tag;
            data_mem[set_idx] <= fill_data_i;
        end else if (update_i) begin
            // write-through hit, merge the stored lanes only
            for (int i = 0; i < `CACHE_SEL_W; i++) begin
                if (update_sel_i[i]) begin
                    data_mem[set_idx][8*i +: 8] <= update_data_i[8*i +: 8];
                end
            end
        end
    end

    always_comb begin
        lookup_o.hit  = valid_q[set_idx] && (tag_mem[set_idx] == addr_tag);
        lookup_o.data = data_mem[set_idx];
    end

    // fill comes from a read, update from a write, never both at once
    a_install_update_excl: assert property (
        @(posedge cpu_clock_i) disable iff (!rst_n_i)
        !(install_i && update_i)
    );

endmodule

`default_nettype wire

//--- design/bus_master.sv
`default_nettype none

module bus_master
    import cache_pkg::*;
(
    input  wire logic    cpu_clock_i,
    input  wire logic    rst_n_i,
    input  wire logic    start_i,
    input  wire logic    we_i,
    input  wire wb_adr_t adr_i,
    input  wire word_t   dat_i,
    input  wire sel_t    sel_i,
    input  wire wb_rsp_t wb_i,
    output wb_req_t      wb_o,
    output bus_done_t    done_o,
    output logic         busy_o
);

    bus_state_t state_q;
    logic       cyc_q;
    logic       stb_q;
    logic       we_q;
    wb_adr_t    adr_q;
    word_t      dat_q;
    sel_t       sel_q;
    logic       accept;
    logic       ending;

    // request phase ends on the first cycle without stall
    assign accept = (state_q == B_REQ) && !wb_i.stall;
    // ack/err may already come with the accepted request
    assign ending = ((state_q == B_WAIT) || accept) && (wb_i.ack || wb_i.err);

    always_ff @(posedge cpu_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= B_IDLE;
            cyc_q   <= 1'b0;
            stb_q   <= 1'b0;
        end else begin
            case (state_q)
                B_IDLE: begin
                    if (start_i) begin
                        cyc_q   <= 1'b1;
                        stb_q   <= 1'b1;
                        state_q <= B_REQ;
                    end
                end
                B_REQ: begin
                    if (accept) begin
                        stb_q <= 1'b0;
                        if (ending) begin
                            cyc_q   <= 1'b0;
                            state_q <= B_IDLE;
                        end else begin
                            state_q <= B_WAIT;
                        end
                    end
                end
                B_WAIT: begin
                    if (ending) begin
                        cyc_q   <= 1'b0;
                        state_q <= B_IDLE;
                    end
                end
                default: begin
                    cyc_q   <= 1'b0;
                    stb_q   <= 1'b0;
                    state_q <= B_IDLE;
                end
            endcase
        end
    end

    // transfer payload, held for the whole cycle
    always_ff @(posedge cpu_clock_i) begin
        if ((state_q == B_IDLE) && start_i) begin
            we_q  <= we_i;
            adr_q <= adr_i;
            dat_q <= dat_i;
            sel_q <= we_i ? sel_i : '1;
        end
    end

    always_comb begin
        wb_o.cyc = cyc_q;
        wb_o.stb = stb_q;
        wb_o.we  = we_q;
        wb_o.adr = adr_q;
        wb_o.dat = dat_q;
        wb_o.sel = sel_q;

        done_o.done  = ending;
        done_o.err   = ending && wb_i.err;
        done_o.we    = we_q;
        done_o.rdata = wb_i.dat;
    end

    assign busy_o = (state_q != B_IDLE);

    a_no_start_busy: assert property (
        @(posedge cpu_clock_i) disable iff (!rst_n_i)
        start_i |-> !busy_o
    );

    a_stb_in_cyc: assert property (
        @(posedge cpu_clock_i) disable iff (!rst_n_i)
        wb_o.stb |-> wb_o.cyc
    );

endmodule

`default_nettype wire

//--- design/cache_ctrl.sv
`default_nettype none

module cache_ctrl
    import cache_pkg::*;
(
    input  wire logic      cpu_clock_i,
    input  wire logic      rst_n_i,
    input  wire cpu_req_t  cpu_req_i,
    input  wire lookup_t   lookup_i,
    input  wire logic      busy_i,
    input  wire bus_done_t done_i,
    output logic           start_o,
    output logic           we_o,
    output wb_adr_t        adr_o,
    output word_t          dat_o,
    output sel_t           sel_o,
    output logic           install_o,
    output logic           update_o,
    output logic           cpu_stall_o,
    output logic           cpu_err_o
);

    word_t fmt_data;
    sel_t  fmt_sel;
    logic  rd_req;
    logic  wr_req;
    logic  done_err;

    store_format u_fmt (
        .data_i   (cpu_req_i.data),
        .offset_i (cpu_req_i.addr[1:0]),
        .size_i   (cpu_req_i.size),
        .data_o   (fmt_data),
        .sel_o    (fmt_sel)
    );

    assign rd_req   = cpu_req_i.valid && !cpu_req_i.write;
    assign wr_req   = cpu_req_i.valid && cpu_req_i.write;
    assign done_err = done_i.done && done_i.err;

    // every store goes out, loads only on a miss
    assign start_o = (wr_req || (rd_req && !lookup_i.hit)) && !busy_i && !done_i.done;
    assign we_o    = cpu_req_i.write;
    assign adr_o   = cpu_req_i.addr[$bits(byte_addr_t)-1:2];
    assign dat_o   = fmt_data;
    assign sel_o   = fmt_sel;

    // fill on a clean read, lane merge only if the store address is cached
    assign install_o = done_i.done && !done_i.err && !done_i.we;
    assign update_o  = done_i.done && !done_i.err && done_i.we && lookup_i.hit;

    // a read is released by the install edge, or right away on error
    assign cpu_stall_o = (rd_req && !lookup_i.hit && !done_err) ||
                         (wr_req && !done_i.done);

    assign cpu_err_o = done_err;

    // the CPU must hold its request across a stall
    a_req_stable: assert property (
        @(posedge cpu_clock_i) disable iff (!rst_n_i)
        cpu_stall_o |=> $stable(cpu_req_i)
    );

endmodule

`default_nettype wire

//--- design/dm_cache_top.sv
`default_nettype none

module dm_cache_top
    import cache_pkg::*;
(
    input  wire logic     cpu_clock_i,
    input  wire logic     rst_n_i,
    input  wire cpu_req_t cpu_req_i,
    input  wire wb_rsp_t  wb_i,
    output word_t         cpu_data_o,
    output logic          cpu_stall_o,
    output logic          cpu_err_o,
    output wb_req_t       wb_o
);

    lookup_t   lookup;
    bus_done_t bus_done;
    logic      bus_start;
    logic      bus_we;
    logic      bus_busy;
    wb_adr_t   bus_adr;
    word_t     bus_dat;
    sel_t      bus_sel;
    logic      install;
    logic      update;

    cache_store u_store (
        .cpu_clock_i   (cpu_clock_i),
        .rst_n_i       (rst_n_i),
        .addr_i        (cpu_req_i.addr),
        .install_i     (install),
        .fill_data_i   (bus_done.rdata),
        .update_i      (update),
        .update_data_i (bus_dat),
        .update_sel_i  (bus_sel),
        .lookup_o      (lookup)
    );

    bus_master u_bus (
        .cpu_clock_i (cpu_clock_i),
        .rst_n_i     (rst_n_i),
        .start_i     (bus_start),
        .we_i        (bus_we),
        .adr_i       (bus_adr),
        .dat_i       (bus_dat),
        .sel_i       (bus_sel),
        .wb_i        (wb_i),
        .wb_o        (wb_o),
        .done_o      (bus_done),
        .busy_o      (bus_busy)
    );

    cache_ctrl u_ctrl (
        .cpu_clock_i (cpu_clock_i),
        .rst_n_i     (rst_n_i),
        .cpu_req_i   (cpu_req_i),
        .lookup_i    (lookup),
        .busy_i      (bus_busy),
        .done_i      (bus_done),
        .start_o     (bus_start),
        .we_o        (bus_we),
        .adr_o       (bus_adr),
        .dat_o       (bus_dat),
        .sel_o       (bus_sel),
        .install_o   (install),
        .update_o    (update),
        .cpu_stall_o (cpu_stall_o),
        .cpu_err_o   (cpu_err_o)
    );

    assign cpu_data_o = lookup.data;

endmodule

`default_nettype wire

//--- tests/wb_mem_model.sv
`default_nettype none

`include "cache_macros.svh"

module wb_mem_model
    import cache_pkg::*;
#(
    parameter wb_adr_t ERR_ADR = 12'h0AB
) (
    input  wire logic    cpu_clock_i,
    input  wire logic    rst_n_i,
    input  wire wb_req_t wb_req_i,
    output wb_rsp_t      wb_rsp_o
);

    word_t      mem [1 << `CACHE_AW];
    logic [15:0] lfsr_q;
    logic [1:0] stall_cnt;
    logic [1:0] ack_cnt;
    logic       pending;
    logic       ack_q;
    logic       err_q;
    word_t      dat_q;
    wb_adr_t    p_adr;
    logic       accept;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    initial begin
        for (int a = 0; a < (1 << `CACHE_AW); a++) begin
            mem[a] = word_t'(a) * 32'h9E37_79B1;
        end
    end

    assign accept = wb_req_i.cyc && wb_req_i.stb && (stall_cnt == 2'd0) && !pending;

    always @(posedge cpu_clock_i or negedge rst_n_i) begin
        logic [15:0] s;
        logic [3:0]  draw;
        if (!rst_n_i) begin
            lfsr_q    <= 16'd16;
            stall_cnt <= 2'd0;
            ack_cnt   <= 2'd0;
            pending   <= 1'b0;
            ack_q     <= 1'b0;
            err_q     <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
            if (wb_req_i.cyc && wb_req_i.stb && stall_cnt != 2'd0) begin
                stall_cnt <= stall_cnt - 2'd1;
            end
            if (accept) begin
                // four bits: ack delay now, stall count for the next request
                s = lfsr_q;
                for (int i = 0; i < 4; i++) begin
                    s = lfsr_step(s);
                    draw[i] = s[0];
                end
                lfsr_q    <= s;
                ack_cnt   <= draw[1:0];
                stall_cnt <= draw[3:2];
                pending   <= 1'b1;
                p_adr     <= wb_req_i.adr;
                if (wb_req_i.we && wb_req_i.adr != ERR_ADR) begin
                    for (int i = 0; i < 4; i++) begin
                        if (wb_req_i.sel[i]) begin
                            mem[wb_req_i.adr][8*i +: 8] <= wb_req_i.dat[8*i +: 8];
                        end
                    end
                end
            end else if (pending) begin
                if (ack_cnt == 2'd0) begin
                    pending <= 1'b0;
                    dat_q   <= mem[p_adr];
                    if (p_adr == ERR_ADR) begin
                        err_q <= 1'b1;
                    end else begin
                        ack_q <= 1'b1;
                    end
                end else begin
                    ack_cnt <= ack_cnt - 2'd1;
                end
            end
        end
    end

    assign wb_rsp_o = '{stall: (stall_cnt != 2'd0), ack: ack_q, dat: dat_q, err: err_q};

endmodule

`default_nettype wire

//--- tests/tb_dm_cache.sv
`default_nettype none

module tb_dm_cache
    import cache_pkg::*;
;

    localparam int N_REQ = 37;
    localparam wb_adr_t ERR_WORD = 12'h0AB;

    logic     clk;
    logic     rst_n;
    cpu_req_t cpu_req;
    wb_req_t  wb_req;
    wb_rsp_t  wb_rsp;
    word_t    cpu_data;
    logic     stall;
    logic     err;

    int       errors;
    int       requests;
    int       test_id;
    int       req_test;
    int       req_id;
    int       last_id;
    logic     req_new;
    logic     chk_reset;
    logic     exp_hit;
    logic     exp_miss;
    logic     exp_err;
    word_t    exp_data;
    wb_adr_t  exp_adr;
    sel_t     exp_sel;
    word_t    exp_dat;
    logic [15:0] lfsr;
    word_t    shadow [int];

    dm_cache_top UUT (
        .cpu_clock_i (clk),
        .rst_n_i     (rst_n),
        .cpu_req_i   (cpu_req),
        .wb_i        (wb_rsp),
        .cpu_data_o  (cpu_data),
        .cpu_stall_o (stall),
        .cpu_err_o   (err),
        .wb_o        (wb_req)
    );

    wb_mem_model #(.ERR_ADR(ERR_WORD)) u_mem (
        .cpu_clock_i (clk),
        .rst_n_i     (rst_n),
        .wb_req_i    (wb_req),
        .wb_rsp_o    (wb_rsp)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        last_id <= req_id;
    end
    assign req_new = (req_id != last_id);

    function automatic string name_of(input int id);
        case (id)
            0: return "reset";
            1: return "read miss and hit";
            2: return "write-through";
            3: return "write hit update";
            4: return "conflict eviction";
            default: return "bus error";
        endcase
    endfunction

    // fibonacci lfsr stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic word_t shadow_word(input int a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return word_t'(a) * 32'h9E37_79B1;
    endfunction

    function automatic sel_t lanes_for(input mem_size_t sz, input logic [1:0] off);
        if (sz == SZ_BYTE) begin
            return sel_t'(4'b0001 << off);
        end else if (sz == SZ_HALF) begin
            return off[1] ? 4'b1100 : 4'b0011;
        end
        return 4'b1111;
    endfunction

    function automatic word_t lane_data(input mem_size_t sz, input word_t d);
        if (sz == SZ_BYTE) begin
            return {4{d[7:0]}};
        end else if (sz == SZ_HALF) begin
            return {2{d[15:0]}};
        end
        return d;
    endfunction

    task automatic request(input logic wr, input int waddr, input logic [1:0] off,
                           input mem_size_t sz, input word_t d,
                           input logic hit, input logic miss, input logic berr);
        sel_t  s;
        word_t ld;
        word_t w;
        s  = lanes_for(sz, off);
        ld = lane_data(sz, d);
        @(posedge clk);
        cpu_req  <= '{addr: byte_addr_t'({waddr[11:0], off}), data: d, size: sz,
                      write: wr, valid: 1'b1};
        req_id   <= req_id + 1;
        req_test <= test_id;
        exp_hit  <= hit;
        exp_miss <= miss;
        exp_err  <= berr;
        exp_data <= shadow_word(waddr);
        exp_adr  <= wb_adr_t'(waddr);
        exp_sel  <= wr ? s : '1;
        exp_dat  <= ld;
        forever begin
            @(negedge clk);
            if (!stall) begin
                break;
            end
        end
        requests++;
        if (wr) begin
            w = shadow_word(waddr);
            for (int i = 0; i < 4; i++) begin
                if (s[i]) begin
                    w[8*i +: 8] = ld[8*i +: 8];
                end
            end
            shadow[waddr] = w;
        end
    endtask

    a_reset: assert property (@(posedge clk) chk_reset |-> !wb_req.cyc && !wb_req.stb && !err)
        else begin
            errors++;
            $display("reset state wrong: cyc, stb or cpu_err_o is high after reset");
        end

    a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_req.valid && !cpu_req.write && !stall && !err |-> cpu_data == exp_data)
        else begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name_of($sampled(req_test)),
                     $sampled(exp_data), $sampled(cpu_data));
        end

    a_hit: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_req.valid && exp_hit |-> !stall && !wb_req.cyc)
        else begin
            errors++;
            $display("%s: a read that should hit stalled or used the bus",
                     name_of($sampled(req_test)));
        end

    a_miss: assert property (@(posedge clk) disable iff (!rst_n)
        req_new && exp_miss |-> stall)
        else begin
            errors++;
            $display("%s: a read that should miss did not stall", name_of($sampled(req_test)));
        end

    a_bus_we: assert property (@(posedge clk) disable iff (!rst_n)
        wb_req.cyc |-> wb_req.we == cpu_req.write)
        else begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name_of($sampled(req_test)),
                     $sampled(cpu_req.write), $sampled(wb_req.we));
        end

    a_bus_adr: assert property (@(posedge clk) disable iff (!rst_n)
        wb_req.cyc && wb_req.stb |-> wb_req.adr == exp_adr)
        else begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name_of($sampled(req_test)),
                     $sampled(exp_adr), $sampled(wb_req.adr));
        end

    a_bus_sel: assert property (@(posedge clk) disable iff (!rst_n)
        wb_req.cyc && wb_req.stb |-> wb_req.sel == exp_sel)
        else begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name_of($sampled(req_test)),
                     $sampled(exp_sel), $sampled(wb_req.sel));
        end

    a_wr_dat: assert property (@(posedge clk) disable iff (!rst_n)
        wb_req.cyc && wb_req.stb && wb_req.we |-> wb_req.dat == exp_dat)
        else begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name_of($sampled(req_test)),
                     $sampled(exp_dat), $sampled(wb_req.dat));
        end

    // a store is held exactly until its ack
    a_wr_release: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_req.valid && cpu_req.write |-> stall == !(wb_req.cyc && (wb_rsp.ack || wb_rsp.err)))
        else begin
            errors++;
            $display("%s: store stall not released in the ack cycle",
                     name_of($sampled(req_test)));
        end

    a_err_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        err |-> exp_err && !stall ##1 !err)
        else begin
            errors++;
            $display("%s: cpu_err_o not a single cycle pulse with stall low",
                     name_of($sampled(req_test)));
        end

    a_err_seen: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_req.valid && exp_err && !stall |-> err)
        else begin
            errors++;
            $display("%s: read of the error address finished without an error",
                     name_of($sampled(req_test)));
        end

    initial begin
        repeat (4 + N_REQ * 40) @(posedge clk);
        $display("timeout: requests stopped completing before the end of the tests");
        $display("Regression failed");
        $finish;
    end

    initial begin
        int   a;
        int   cached [4];
        logic [1:0] off;
        mem_size_t sz;
        clk = 1'b0;
        rst_n = 1'b0;
        cpu_req = '0;
        errors = 0;
        requests = 0;
        test_id = 0;
        req_test = 0;
        req_id = 0;
        last_id = 0;
        chk_reset = 1'b0;
        exp_hit = 1'b0;
        exp_miss = 1'b0;
        exp_err = 1'b0;
        exp_data = '0;
        exp_adr = '0;
        exp_sel = '0;
        exp_dat = '0;
        lfsr = 16'd16;
        cached = '{32'h001, 32'h023, 32'h145, 32'h2F7};
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        chk_reset <= 1'b1;
        @(posedge clk);
        chk_reset <= 1'b0;

        test_id = 1;
        foreach (cached[i]) begin
            request(1'b0, cached[i], 2'd0, SZ_WORD, '0, 1'b0, 1'b1, 1'b0);
            request(1'b0, cached[i], 2'd0, SZ_WORD, '0, 1'b1, 1'b0, 1'b0);
        end

        for (int i = 0; i < 8; i++) begin
            test_id = 2;
            a = cached[take_bits(2)];
            sz = mem_size_t'(take_bits(2) % 3);
            off = (sz == SZ_WORD) ? 2'd0 : 2'(take_bits(2));
            request(1'b1, a, off, sz, take_bits(32), 1'b0, 1'b0, 1'b0);
            test_id = 3;
            request(1'b0, a, 2'd0, SZ_WORD, '0, 1'b1, 1'b0, 1'b0);
        end

        // no allocate on a store miss
        test_id = 2;
        request(1'b1, 32'h3A2, 2'd2, SZ_HALF, 32'h0000_BEEF, 1'b0, 1'b0, 1'b0);
        request(1'b0, 32'h3A2, 2'd0, SZ_WORD, '0, 1'b0, 1'b1, 1'b0);
        request(1'b1, 32'h3A2, 2'd1, SZ_BYTE, 32'h0000_005A, 1'b0, 1'b0, 1'b0);
        test_id = 3;
        request(1'b0, 32'h3A2, 2'd0, SZ_WORD, '0, 1'b1, 1'b0, 1'b0);

        test_id = 4;
        for (int i = 0; i < 3; i++) begin
            request(1'b0, 32'h049, 2'd0, SZ_WORD, '0, 1'b0, 1'b1, 1'b0);
            request(1'b0, 32'h159, 2'd0, SZ_WORD, '0, 1'b0, 1'b1, 1'b0);
        end

        test_id = 5;
        request(1'b0, int'(ERR_WORD), 2'd0, SZ_WORD, '0, 1'b0, 1'b1, 1'b1);
        request(1'b0, int'(ERR_WORD), 2'd0, SZ_WORD, '0, 1'b0, 1'b1, 1'b1);
        request(1'b0, 32'h0AC, 2'd0, SZ_WORD, '0, 1'b0, 1'b1, 1'b0);

        @(posedge clk);
        cpu_req.valid <= 1'b0;
        repeat (3) @(posedge clk);
        $display("requests completed: %0d, errors: %0d", requests, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+design
design/cache_pkg.sv
design/store_format.sv
design/cache_store.sv
design/bus_master.sv
design/cache_ctrl.sv
design/dm_cache_top.sv
tests/wb_mem_model.sv
tests/tb_dm_cache.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_dm_cache
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
PASS_MSG  := Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
